//--- design/uart_pkg.sv
package uart_pkg;

    // rate setup, shared by the tick generator, tx and rx
    localparam int CLKS_PER_TICK = 4;                   // system clocks per oversample tick
    localparam int TICKS_PER_BIT = 16;                  // oversample ticks per serial bit
    localparam int TICKS_TO_BIT  = TICKS_PER_BIT - 1;   // last tick index of a bit
    localparam int TICKS_TO_MID  = TICKS_TO_BIT / 2;    // mid-bit tick index
    localparam int DATA_BITS     = 8;                   // 8N1 only

    localparam int TICK_CNT_W = $clog2(TICKS_PER_BIT);
    localparam int CLK_DIV_W  = $clog2(CLKS_PER_TICK);

    typedef logic [DATA_BITS-1:0]  uart_byte_t;
    typedef logic [TICK_CNT_W-1:0] tick_cnt_t;   // counts 0..TICKS_TO_BIT
    typedef logic [3:0]            bit_cnt_t;    // bit 3 set once eight bits are in
    typedef logic [CLK_DIV_W-1:0]  clk_div_t;    // clock divider inside the tick generator

    // transmit request, valid is a single-cycle strobe
    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } tx_req_t;

    // receive result, valid is the one-cycle done strobe
    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } rx_result_t;

    typedef enum logic [4:0] {
        RX_IDLE  = 5'b00001,
        RX_START = 5'b00010,
        RX_DATA  = 5'b00100,
        RX_STOP  = 5'b01000,
        RX_DONE  = 5'b10000
    } rx_state_t;   // one-hot

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

//--- design/uart_tick_gen.sv
`timescale 1ns/1ps

// oversampling enable for both directions
module uart_tick_gen
    import uart_pkg::*;
(
    input  logic i_clk,
    input  logic reset,
    output logic o_tick
);

    clk_div_t div_cnt;   // free-running clock divider
    logic     div_wrap;  // last clock of a tick period

    assign div_wrap = (div_cnt == clk_div_t'(CLKS_PER_TICK - 1));

    always_ff @(posedge i_clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (div_wrap) begin
            div_cnt <= '0;               // wrap back to start
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // one-cycle strobe on the wrap
    // first pulse lands on the CLKS_PER_TICK-th clock after reset release
    assign o_tick = div_wrap;

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps

// 8N1 transmitter paced by the shared oversample tick
module uart_tx
    import uart_pkg::*;
(
    input  logic    i_clk,
    input  logic    reset,
    input  logic    i_tick,
    input  tx_req_t i_tx,
    output logic    o_txd,
    output logic    o_tx_busy
);

    tx_state_t  state;
    tick_cnt_t  tick_cnt;   // ticks into the current bit
    bit_cnt_t   bit_cnt;    // data bits already sent
    uart_byte_t shift_q;    // outgoing byte, LSB on bit 0

    logic accept;           // request taken this cycle
    logic bit_end;          // last tick of the current bit
    logic last_data;        // eighth data bit on the line

    assign accept    = (state == TX_IDLE) && i_tx.valid;   // busy requests just drop
    assign bit_end   = i_tick && (tick_cnt == tick_cnt_t'(TICKS_TO_BIT));
    assign last_data = (bit_cnt == bit_cnt_t'(DATA_BITS - 1));

    // control state
    always_ff @(posedge i_clk or posedge reset) begin
        if (reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    tick_cnt <= '0;        // fresh bit timing per frame
                    bit_cnt  <= '0;
                    if (accept) begin
                        state <= TX_START;   // start bit goes out next cycle
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_data) begin
                            state <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state <= TX_IDLE;    // busy drops after a full stop bit
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase

            // bit timer runs only on ticks while a frame is out
            if (state != TX_IDLE && i_tick) begin
                if (bit_end) begin
                    tick_cnt <= '0;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

    // payload shifter
    always_ff @(posedge i_clk) begin
        if (accept) begin
            shift_q <= i_tx.data;                              // latch on accept
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[DATA_BITS-1:1]};          // next bit to bit 0
        end
    end

    // line level straight from the state
    always_comb begin
        case (state)
            TX_START: o_txd = 1'b0;          // start bit
            TX_DATA:  o_txd = shift_q[0];    // LSB first
            default:  o_txd = 1'b1;          // idle and stop are mark
        endcase
    end

    assign o_tx_busy = (state != TX_IDLE);

endmodule

//--- design/uart_rx.sv
`timescale 1ns/1ps

// oversampling 8N1 receiver
module uart_rx
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       reset,
    input  logic       i_tick,
    input  logic       i_rxd,
    output rx_result_t o_rx,
    output logic       o_rx_busy
);

    rx_state_t  state;
    rx_state_t  next_state;

    logic       rxd_meta;    // first sync stage
    logic       rxd_sync;    // second sync stage
    logic       rxd_prev;    // line level at the previous tick

    tick_cnt_t  tick_cnt;    // ticks into the current bit
    tick_cnt_t  tick_cmp;    // target for tick_cnt, depends on state
    bit_cnt_t   bit_cnt;     // data bits taken so far
    uart_byte_t rx_data;     // shift register filled from the MSB end
    uart_byte_t rx_last;     // last complete byte shown on o_rx.data

    logic       falling;     // falling edge seen on a tick
    logic       tick_ovf;    // tick_cnt hit its target on a tick
    logic       bit_ovf;     // all eight bits taken

    // async serial in goes through two flops before use
    always_ff @(posedge i_clk or posedge reset) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            {rxd_sync, rxd_meta} <= {rxd_meta, i_rxd};
        end
    end

    // edge register advances with the tick only
    always_ff @(posedge i_clk or posedge reset) begin
        if (reset) begin
            rxd_prev <= 1'b1;
        end else if (i_tick) begin
            rxd_prev <= rxd_sync;
        end
    end

    assign falling  = i_tick & ~rxd_sync & rxd_prev;   // first tick with the line low
    assign tick_ovf = i_tick & (tick_cnt == tick_cmp);
    assign bit_ovf  = bit_cnt[3];                      // count reached 8

    // next state and comparator select
    always_comb begin
        next_state = state;
        tick_cmp   = tick_cnt_t'(TICKS_TO_BIT);
        case (state)
            RX_IDLE: begin
                tick_cmp = tick_cnt_t'(TICKS_TO_MID);
                if (falling) begin
                    next_state = RX_START;
                end
            end
            RX_START: begin
                tick_cmp = tick_cnt_t'(TICKS_TO_MID);   // half a bit to mid-start
                if (tick_ovf) begin
                    // line back high at mid-start means a glitch
                    next_state = rxd_sync ? RX_IDLE : RX_DATA;
                end
            end
            RX_DATA: begin
                if (bit_ovf) begin
                    next_state = RX_STOP;
                end
            end
            RX_STOP: begin
                if (tick_ovf) begin
                    next_state = RX_DONE;   // mid stop bit with the level not checked
                end
            end
            RX_DONE: begin
                next_state = RX_IDLE;       // single done cycle
            end
            default: begin
                next_state = RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge reset) begin
        if (reset) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_data  <= '0;
            rx_last  <= '0;
        end else begin
            state <= next_state;

            if (state == RX_IDLE) begin
                tick_cnt <= '0;
                bit_cnt  <= '0;
            end

            // bit timer runs on ticks while a frame is being taken
            if ((state == RX_START || state == RX_DATA || state == RX_STOP) && i_tick) begin
                if (tick_ovf) begin
                    tick_cnt <= '0;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end

            // sample at mid-bit
            if (state == RX_DATA && tick_ovf && !bit_ovf) begin
                bit_cnt <= bit_cnt + 1'b1;
                rx_data <= {rxd_sync, rx_data[DATA_BITS-1:1]};   // enters at MSB and ends LSB first
            end

            // byte goes out as the done cycle starts
            if (state == RX_STOP && tick_ovf) begin
                rx_last <= rx_data;
            end
        end
    end

    assign o_rx.valid = (state == RX_DONE);
    assign o_rx.data  = rx_last;
    assign o_rx_busy  = (state != RX_IDLE);

endmodule

//--- design/uart_core.sv
`timescale 1ns/1ps

// one tick source feeds both directions, so tx and rx rates match
module uart_core
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       reset,
    input  tx_req_t    i_tx,
    output logic       o_txd,
    output logic       o_tx_busy,
    input  logic       i_rxd,
    output rx_result_t o_rx,
    output logic       o_rx_busy
);

    logic tick;   // oversample enable

    uart_tick_gen u_tick_gen (
        .i_clk  (i_clk),
        .reset  (reset),
        .o_tick (tick)
    );

    // transmit side
    uart_tx u_tx (
        .i_clk     (i_clk),
        .reset     (reset),
        .i_tick    (tick),
        .i_tx      (i_tx),
        .o_txd     (o_txd),
        .o_tx_busy (o_tx_busy)
    );

    // receive side
    uart_rx u_rx (
        .i_clk     (i_clk),
        .reset     (reset),
        .i_tick    (tick),
        .i_rxd     (i_rxd),
        .o_rx      (o_rx),
        .o_rx_busy (o_rx_busy)
    );

endmodule

//--- test/uart_core_sva.sv
`timescale 1ns/1ps

// protocol checks, bound into uart_core
module uart_core_sva
    import uart_pkg::*;
(
    input logic       i_clk,
    input logic       reset,
    input logic       i_tick,      // internal oversample enable
    input logic       i_txd,
    input logic       i_tx_busy,
    input rx_result_t i_rx
);

    // done strobe lasts exactly one cycle
    property p_rx_valid_single;
        @(posedge i_clk) disable iff (reset)
            i_rx.valid |=> !i_rx.valid;
    endproperty

    // line rests at mark between frames
    property p_txd_idle_high;
        @(posedge i_clk) disable iff (reset)
            !i_tx_busy |-> i_txd;
    endproperty

    property p_tick_single;
        @(posedge i_clk) disable iff (reset)
            i_tick |=> !i_tick;    // divider is at least 2
    endproperty

    a_rx_valid_single: assert property (p_rx_valid_single)
        else $error("o_rx.valid high on two consecutive cycles");

    a_txd_idle_high: assert property (p_txd_idle_high)
        else $error("o_txd low while the transmitter is idle");

    a_tick_single: assert property (p_tick_single)
        else $error("oversample tick on two consecutive cycles");

endmodule

//--- test/tb_uart_core.sv
`timescale 1ns/1ps

module tb_uart_core
    import uart_pkg::*;
();

    localparam int CLK_PERIOD_NS  = 4;
    localparam int BIT_CLKS       = CLKS_PER_TICK * TICKS_PER_BIT;   // 64 clocks per bit
    localparam int FRAME_CLKS     = (DATA_BITS + 2) * BIT_CLKS;      // start, 8 data, stop
    localparam int PLANNED_FRAMES = 34;                              // 8 + 16 + 8 + 1 + 1
    localparam int TIMEOUT_CLKS   = PLANNED_FRAMES * 2 * FRAME_CLKS + 16 * FRAME_CLKS;

    logic       i_clk = 1'b0;
    logic       reset;
    tx_req_t    tx_req;
    logic       txd;
    logic       tx_busy;
    logic       rxd_line;     // what the DUT sees on i_rxd
    logic       line_level;   // line model output
    logic       loopback;     // 1 = i_rxd follows o_txd
    rx_result_t rx_result;
    logic       rx_busy;

    int         seed = 640;
    uart_byte_t exp_q[$];     // bytes still owed by the receiver
    uart_byte_t last_rx = '0; // byte o_rx.data must hold between strobes

    always #(CLK_PERIOD_NS / 2) i_clk = ~i_clk;

    assign rxd_line = loopback ? txd : line_level;

    uart_core u_uart_core (
        .i_clk     (i_clk),
        .reset     (reset),
        .i_tx      (tx_req),
        .o_txd     (txd),
        .o_tx_busy (tx_busy),
        .i_rxd     (rxd_line),
        .o_rx      (rx_result),
        .o_rx_busy (rx_busy)
    );

    bind uart_core uart_core_sva u_core_sva (
        .i_clk     (i_clk),
        .reset     (reset),
        .i_tick    (tick),
        .i_txd     (o_txd),
        .i_tx_busy (o_tx_busy),
        .i_rx      (o_rx)
    );

    // expected line level of bit idx in an 8N1 frame
    function automatic logic frame_bit(input uart_byte_t b, input int idx);
        uart_byte_t sh;
        if (idx == 0) begin
            return 1'b0;                 // start
        end
        if (idx > DATA_BITS) begin
            return 1'b1;                 // stop
        end
        sh = b >> (idx - 1);             // data LSB first
        return sh[0];
    endfunction

    function automatic uart_byte_t rand_byte();
        return uart_byte_t'($random(seed));
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t got);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] t=%0t %s expected %02h got %02h",
                               $time, name, exp, got));
        end
    endtask

    // advance n clocks and land 1 ns after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge i_clk);
        #1;
    endtask

    task automatic send_byte(input uart_byte_t b);
        tx_req.valid = 1'b1;
        tx_req.data  = b;
        step(1);                         // one-cycle strobe
        tx_req.valid = 1'b0;
    endtask

    task automatic wait_tx_idle();
        while (tx_busy !== 1'b0) begin
            step(1);
        end
    endtask

    // line model sending one frame at the nominal bit period
    task automatic drive_frame(input uart_byte_t b);
        for (int k = 0; k < DATA_BITS + 2; k++) begin
            line_level = frame_bit(b, k);
            step(BIT_CLKS);
        end
    endtask

    // wait for every owed byte and then a quiet gap to catch stray strobes
    task automatic drain_rx();
        while (exp_q.size() != 0) begin
            step(1);
        end
        step(2 * FRAME_CLKS);
        check_bit("o_rx_busy", 1'b0, rx_busy);
    endtask

    // receive checker sampled mid-cycle
    always @(negedge i_clk) begin
        if (reset === 1'b0 && rx_result.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_run($sformatf("t=%0t o_rx.valid pulsed with no byte outstanding (data %02h)",
                                   $time, rx_result.data));
            end else begin
                last_rx = exp_q.pop_front();
                check_byte("o_rx.data", last_rx, rx_result.data);
            end
        end else if (reset === 1'b0) begin
            check_byte("o_rx.data", last_rx, rx_result.data);   // held until the next byte
        end
    end

    task automatic after_reset();
        check_bit("o_txd", 1'b1, txd);
        check_bit("o_tx_busy", 1'b0, tx_busy);
        check_bit("o_rx.valid", 1'b0, rx_result.valid);
        check_bit("o_rx_busy", 1'b0, rx_busy);
        check_byte("o_rx.data", 8'h00, rx_result.data);
    endtask

    // sample each bit near its middle since the tick phase spans only 3 clocks
    task automatic tx_waveform();
        uart_byte_t b;
        for (int i = 0; i < 8; i++) begin
            b = rand_byte();
            send_byte(b);
            @(negedge i_clk);
            while (txd !== 1'b0) begin
                @(negedge i_clk);        // start bit edge
            end
            for (int k = 0; k < DATA_BITS + 2; k++) begin
                repeat ((k == 0) ? BIT_CLKS / 2 : BIT_CLKS) @(negedge i_clk);
                check_bit($sformatf("o_txd bit %0d", k), frame_bit(b, k), txd);
                check_bit("o_tx_busy", 1'b1, tx_busy);
            end
            step(1);
            wait_tx_idle();
            check_bit("o_txd", 1'b1, txd);
        end
    endtask

    task automatic loopback_bytes();
        uart_byte_t b;
        loopback = 1'b1;
        for (int i = 0; i < 16; i++) begin
            b = rand_byte();
            exp_q.push_back(b);
            send_byte(b);
            wait_tx_idle();
        end
        drain_rx();
    endtask

    task automatic direct_receive();
        uart_byte_t pattern [4] = '{8'h00, 8'hFF, 8'h55, 8'hA5};
        uart_byte_t b;
        loopback = 1'b0;
        for (int i = 0; i < 8; i++) begin
            b = (i < 4) ? pattern[i] : rand_byte();   // corner bytes first
            exp_q.push_back(b);
            drive_frame(b);                           // back to back frames
        end
        drain_rx();
    endtask

    // quarter-bit glitch must not produce a byte
    task automatic false_start();
        uart_byte_t b;
        loopback   = 1'b0;
        line_level = 1'b0;
        step(BIT_CLKS / 4);
        line_level = 1'b1;
        step(2 * FRAME_CLKS);
        check_bit("o_rx_busy", 1'b0, rx_busy);
        b = rand_byte();
        exp_q.push_back(b);
        drive_frame(b);
        drain_rx();
    endtask

    task automatic busy_request();
        uart_byte_t first;
        uart_byte_t second;
        loopback = 1'b1;
        first    = rand_byte();
        second   = ~first;               // differs in every bit
        exp_q.push_back(first);
        send_byte(first);
        step(3 * BIT_CLKS);
        check_bit("o_tx_busy", 1'b1, tx_busy);
        send_byte(second);               // dropped by the DUT
        check_bit("o_tx_busy", 1'b1, tx_busy);
        wait_tx_idle();
        drain_rx();
        check_bit("o_tx_busy", 1'b0, tx_busy);
    endtask

    initial begin : watchdog
        #(TIMEOUT_CLKS * CLK_PERIOD_NS);
        fail_run($sformatf("run timed out after %0d clocks, a wait never completed",
                           TIMEOUT_CLKS));
    end

    initial begin
        reset      = 1'b1;
        tx_req     = '0;
        line_level = 1'b1;               // idle mark
        loopback   = 1'b0;
        repeat (10) @(posedge i_clk);
        #1;
        reset = 1'b0;
        step(1);
        after_reset();
        tx_waveform();
        loopback_bytes();
        direct_receive();
        false_start();
        busy_request();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- uart_core.f
design/uart_pkg.sv
design/uart_tick_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_core.sv
test/uart_core_sva.sv
test/tb_uart_core.sv

//--- Makefile
# Verilator build and run for uart_core

VERILATOR ?= verilator
TOP       ?= tb_uart_core
FILELIST  ?= uart_core.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

# build, run, then judge the run from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST PASSED" $(LOG); then \
		echo "simulation passed, log in $(LOG)"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
